// ==== include/armDefs.svh ====
`ifndef ARM_DEFS_SVH
`define ARM_DEFS_SVH

// Instruction class in bits 27:26
`define OP_TYPE_DP     2'b00
`define OP_TYPE_MEM    2'b01
`define OP_TYPE_BR     2'b10

// Condition field
`define COND_EQ        4'b0000
`define COND_NE        4'b0001
`define COND_AL        4'b1110

// Data-processing opcodes
`define OPC_AND        4'b0000
`define OPC_SUB        4'b0010
`define OPC_ADD        4'b0100
`define OPC_ORR        4'b1100

// Operand bypass selects
`define FWD_REGFILE    2'b00
`define FWD_RESULTW    2'b01
`define FWD_ALUOUTM    2'b10

`endif

// ==== logic/armPkg.sv ====
`include "armDefs.svh"

package armPkg;

  typedef logic [3:0] regAddrT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef enum logic [1:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr
  } aluOp;

  typedef enum logic [1:0] {
    fwdRegFile = `FWD_REGFILE,
    fwdResultW = `FWD_RESULTW,
    fwdAluOutM = `FWD_ALUOUTM
  } fwdSel;

  // ========================================
  // Instruction word views
  // ========================================

  // Second operand, immediate form or register form
  typedef struct packed {
    logic [3:0] rotate;
    logic [7:0] imm8;
  } dpImmT;

  typedef struct packed {
    logic [7:0] shift;
    regAddrT    rm;
  } dpRegT;

  typedef union packed {
    dpImmT immOp;
    dpRegT regOp;
  } operand2T;

  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] opType;
    logic       immBit;
    logic [3:0] opcode;
    logic       setFlags;
    regAddrT    rn;
    regAddrT    rd;
    operand2T   operand2;
  } dataProcT;

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  opType;
    logic        immBit;
    logic        preIndex;
    logic        upBit;
    logic        byteBit;
    logic        writeBack;
    logic        loadBit;
    regAddrT     rn;
    regAddrT     rd;
    logic [11:0] offset12;
  } memAccessT;

  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  opType;
    logic [1:0]  funct;
    logic [23:0] offset24;
  } branchT;

  typedef union packed {
    dataProcT  dataProc;
    memAccessT mem;
    branchT    branch;
  } instrWord;

endpackage

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
  parameter int DataWidth = 32
) (
  input  logic                 clk,
  input  logic                 writeEnable,
  input  armPkg::regAddrT      ra1,
  input  armPkg::regAddrT      ra2,
  input  armPkg::regAddrT      wa3,
  input  logic [DataWidth-1:0] wd3,
  input  logic [DataWidth-1:0] r15,
  output logic [DataWidth-1:0] rd1,
  output logic [DataWidth-1:0] rd2
);

  // R0 to R14, R15 is the PC and never stored here
  logic [DataWidth-1:0] regs [0:14];

  // Falling edge write, so decode sees a writeback from the same cycle
  always_ff @(negedge clk) begin
    if (writeEnable && (wa3 != 4'hf)) begin
      regs[wa3] <= wd3;
    end
  end

  always_comb begin
    rd1 = (ra1 == 4'hf) ? r15 : regs[ra1];
    rd2 = (ra2 == 4'hf) ? r15 : regs[ra2];
  end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu #(
  parameter int DataWidth = 32
) (
  input  logic [DataWidth-1:0] a,
  input  logic [DataWidth-1:0] b,
  input  armPkg::aluOp         control,
  output logic [DataWidth-1:0] result,
  output armPkg::flagsT        flags
);

  import armPkg::*;

  logic [DataWidth-1:0] bOperand;
  logic [DataWidth:0]   sum;
  logic                 isArith;

  always_comb begin
    // Subtract as a plus not b plus one
    bOperand = (control == aluSub) ? ~b : b;
    sum      = {1'b0, a} + {1'b0, bOperand} + (DataWidth+1)'(control == aluSub);
    isArith  = (control == aluAdd) || (control == aluSub);

    case (control)
      aluAnd:  result = a & b;
      aluOrr:  result = a | b;
      default: result = sum[DataWidth-1:0];
    endcase

    flags.n = result[DataWidth-1];
    flags.z = (result == '0);
    // C and V only meaningful for add and subtract
    flags.c = isArith & sum[DataWidth];
    flags.v = isArith & ~(a[DataWidth-1] ^ bOperand[DataWidth-1])
                      & (a[DataWidth-1] ^ sum[DataWidth-1]);
  end

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
  input  logic          clk,
  input  logic          reset,
  input  logic          match1EM,
  input  logic          match1EW,
  input  logic          match2EM,
  input  logic          match2EW,
  input  logic          match12DE,
  input  logic          regWriteM,
  input  logic          regWriteW,
  input  logic          memToRegE,
  input  logic          branchTaken,
  output armPkg::fwdSel forwardA,
  output armPkg::fwdSel forwardB,
  output logic          stallF,
  output logic          stallD,
  output logic          flushD,
  output logic          flushE
);

  import armPkg::*;

  logic loadStall;

  // Memory stage result is newer, so it wins over writeback
  always_comb begin
    if (match1EM && regWriteM)      forwardA = fwdAluOutM;
    else if (match1EW && regWriteW) forwardA = fwdResultW;
    else                            forwardA = fwdRegFile;

    if (match2EM && regWriteM)      forwardB = fwdAluOutM;
    else if (match2EW && regWriteW) forwardB = fwdResultW;
    else                            forwardB = fwdRegFile;
  end

  // Load in execute with its result needed in decode
  assign loadStall = match12DE & memToRegE;

  assign stallF = loadStall;
  assign stallD = loadStall;
  assign flushD = branchTaken;
  assign flushE = loadStall | branchTaken;

  // A load-use stall inserts one bubble and then releases
  assert property (@(posedge clk) disable iff (reset) stallD |=> !stallD);

endmodule

// ==== logic/controller.sv ====
`timescale 1ns/1ps
`include "armDefs.svh"

module controller (
  input  logic             clk,
  input  logic             reset,
  input  armPkg::instrWord instrD,
  input  armPkg::flagsT    flagsE,
  input  logic             stallD,
  input  logic             flushD,
  input  logic             flushE,
  output logic [1:0]       regSrc,
  output logic [1:0]       immSelect,
  output armPkg::aluOp     aluControl,
  output logic             aluSrc,
  output logic             branchTaken,
  output logic             memWrite,
  output logic             memToReg,
  output logic             regWrite,
  output logic             regWriteM,
  output logic             memToRegE
);

  import armPkg::*;

  logic       validD;
  logic       regWriteD, memWriteD, memToRegD, branchD, flagWriteD, aluSrcD;
  aluOp       aluControlD;
  logic       regWriteE, memWriteE, branchE, flagWriteE;
  logic [3:0] condE;
  logic       condPass;
  logic       memToRegM;
  flagsT      flagsReg;

  // Decode slot holds a real instruction only after a fetch that was not flushed
  always_ff @(posedge clk) begin
    if (reset || flushD) validD <= 1'b0;
    else if (!stallD)    validD <= 1'b1;
  end

  // ========================================
  // Decode
  // ========================================
  always_comb begin
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memToRegD = 1'b0;
    branchD = 1'b0;
    flagWriteD = 1'b0;
    aluSrcD = 1'b1;
    aluControlD = aluAdd;
    regSrc = 2'b00;
    immSelect = 2'b00;
    case (instrD.dataProc.opType)
      `OP_TYPE_DP: begin
        regWriteD = validD;
        flagWriteD = validD & instrD.dataProc.setFlags;
        aluSrcD = instrD.dataProc.immBit;
        case (instrD.dataProc.opcode)
          `OPC_SUB: aluControlD = aluSub;
          `OPC_AND: aluControlD = aluAnd;
          `OPC_ORR: aluControlD = aluOrr;
          default:  aluControlD = aluAdd;
        endcase
      end
      `OP_TYPE_MEM: begin
        regWriteD = validD & instrD.mem.loadBit;
        memToRegD = validD & instrD.mem.loadBit;
        memWriteD = validD & ~instrD.mem.loadBit;
        // Stores read Rd on the second port
        regSrc = {~instrD.mem.loadBit, 1'b0};
        immSelect = 2'b01;
      end
      `OP_TYPE_BR: begin
        branchD = validD;
        regSrc = 2'b01;
        immSelect = 2'b10;
      end
      default: ;
    endcase
  end

  // ========================================
  // Execute
  // ========================================
  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      branchE <= 1'b0;
      flagWriteE <= 1'b0;
    end else begin
      regWriteE <= regWriteD;
      memWriteE <= memWriteD;
      memToRegE <= memToRegD;
      branchE <= branchD;
      flagWriteE <= flagWriteD;
    end
  end

  always_ff @(posedge clk) begin
    aluControl <= aluControlD;
    aluSrc <= aluSrcD;
    condE <= instrD.dataProc.cond;
  end

  always_comb begin
    case (condE)
      `COND_EQ: condPass = flagsReg.z;
      `COND_NE: condPass = ~flagsReg.z;
      `COND_AL: condPass = 1'b1;
      default:  condPass = 1'b0;
    endcase
  end

  assign branchTaken = branchE & condPass;

  always_ff @(posedge clk) begin
    if (reset) flagsReg <= '0;
    else if (flagWriteE && condPass) flagsReg <= flagsE;
  end

  // Memory and writeback
  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteM <= 1'b0;
      memWrite <= 1'b0;
      memToRegM <= 1'b0;
      regWrite <= 1'b0;
      memToReg <= 1'b0;
    end else begin
      regWriteM <= regWriteE & condPass;
      memWrite <= memWriteE & condPass;
      memToRegM <= memToRegE;
      regWrite <= regWriteM;
      memToReg <= memToRegM;
    end
  end

  // Nothing fetched behind a taken branch reaches execute
  assert property (@(posedge clk) disable iff (reset)
                   branchTaken |=> !(regWriteE || memWriteE || branchE));

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
  parameter int DataWidth = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [1:0]           regSrc,
  input  logic [1:0]           immSelect,
  input  armPkg::aluOp         aluControl,
  input  logic                 aluSrc,
  input  logic                 branchTaken,
  input  logic                 memToReg,
  input  logic                 regWrite,
  input  logic                 stallF,
  input  logic                 stallD,
  input  logic                 flushD,
  input  armPkg::fwdSel        forwardA,
  input  armPkg::fwdSel        forwardB,
  output armPkg::instrWord     instrD,
  output armPkg::flagsT        flagsE,
  output logic                 match1EM,
  output logic                 match1EW,
  output logic                 match2EM,
  output logic                 match2EW,
  output logic                 match12DE,
  output logic [DataWidth-1:0] pc,
  input  logic [31:0]          instr,
  output logic [DataWidth-1:0] dataAddr,
  output logic [DataWidth-1:0] writeData,
  input  logic [DataWidth-1:0] readData
);

  import armPkg::*;

  logic [DataWidth-1:0] pcPlus4, pcNext;
  logic [DataWidth-1:0] rd1D, rd2D, extImmD, memOffsetD;
  regAddrT              ra1D, ra2D;
  logic [DataWidth-1:0] rd1E, rd2E, extImmE, srcA, srcB, writeDataE, aluResultE;
  regAddrT              ra1E, ra2E, wa3E;
  logic [DataWidth-1:0] aluOutM, writeDataM;
  regAddrT              wa3M;
  logic [DataWidth-1:0] aluOutW, readDataW, resultW;
  regAddrT              wa3W;

  // ========================================
  // Fetch
  // ========================================
  assign pcPlus4 = pc + DataWidth'(4);
  assign pcNext = branchTaken ? aluResultE : pcPlus4;

  always_ff @(posedge clk) begin
    if (reset)        pc <= '0;
    else if (!stallF) pc <= pcNext;
  end

  // ========================================
  // Decode
  // ========================================
  always_ff @(posedge clk) begin
    if (reset || flushD) instrD <= '0;
    else if (!stallD)    instrD <= instr;
  end

  // Branches read R15 as the base, stores read Rd as the data
  assign ra1D = regSrc[0] ? 4'hf : instrD.dataProc.rn;
  assign ra2D = regSrc[1] ? instrD.mem.rd : instrD.dataProc.operand2.regOp.rm;

  // Fetch PC plus 4 is the decode PC plus 8
  regFile #(.DataWidth(DataWidth)) u_regFile (
    .clk         (clk),
    .writeEnable (regWrite),
    .ra1         (ra1D),
    .ra2         (ra2D),
    .wa3         (wa3W),
    .wd3         (resultW),
    .r15         (pcPlus4),
    .rd1         (rd1D),
    .rd2         (rd2D)
  );

  assign memOffsetD = DataWidth'(instrD.mem.offset12);

  always_comb begin
    case (immSelect)
      2'b01:   extImmD = instrD.mem.upBit ? memOffsetD : ('0 - memOffsetD);
      // Word offset, sign extended
      2'b10:   extImmD = DataWidth'($signed({instrD.branch.offset24, 2'b00}));
      default: extImmD = DataWidth'(instrD.dataProc.operand2.immOp.imm8);
    endcase
  end

  // ========================================
  // Execute
  // ========================================
  always_ff @(posedge clk) begin
    rd1E <= rd1D;
    rd2E <= rd2D;
    extImmE <= extImmD;
    ra1E <= ra1D;
    ra2E <= ra2D;
    wa3E <= instrD.dataProc.rd;
  end

  always_comb begin
    case (forwardA)
      fwdResultW: srcA = resultW;
      fwdAluOutM: srcA = aluOutM;
      default:    srcA = rd1E;
    endcase
    case (forwardB)
      fwdResultW: writeDataE = resultW;
      fwdAluOutM: writeDataE = aluOutM;
      default:    writeDataE = rd2E;
    endcase
  end

  assign srcB = aluSrc ? extImmE : writeDataE;

  alu #(.DataWidth(DataWidth)) u_alu (
    .a       (srcA),
    .b       (srcB),
    .control (aluControl),
    .result  (aluResultE),
    .flags   (flagsE)
  );

  // ========================================
  // Memory and writeback
  // ========================================
  always_ff @(posedge clk) begin
    aluOutM <= aluResultE;
    writeDataM <= writeDataE;
    wa3M <= wa3E;
    aluOutW <= aluOutM;
    readDataW <= readData;
    wa3W <= wa3M;
  end

  assign dataAddr = aluOutM;
  assign writeData = writeDataM;
  assign resultW = memToReg ? readDataW : aluOutW;

  // Hazard comparisons
  assign match1EM = (wa3M == ra1E);
  assign match1EW = (wa3W == ra1E);
  assign match2EM = (wa3M == ra2E);
  assign match2EW = (wa3W == ra2E);
  assign match12DE = (wa3E == ra1D) | (wa3E == ra2D);

  // Branch targets keep word alignment
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== logic/armCore.sv ====
`timescale 1ns/1ps

module armCore #(
  parameter int DataWidth = 32
) (
  input  logic                 clk,
  input  logic                 reset,
  output logic [DataWidth-1:0] pc,
  input  logic [31:0]          instr,
  output logic                 memWrite,
  output logic [DataWidth-1:0] dataAddr,
  output logic [DataWidth-1:0] writeData,
  input  logic [DataWidth-1:0] readData
);

  import armPkg::*;

  instrWord   instrD;
  flagsT      flagsE;
  logic [1:0] regSrc, immSelect;
  aluOp       aluControl;
  logic       aluSrc, branchTaken, memToReg, regWrite, regWriteM, memToRegE;
  logic       match1EM, match1EW, match2EM, match2EW, match12DE;
  fwdSel      forwardA, forwardB;
  logic       stallF, stallD, flushD, flushE;

  datapath #(.DataWidth(DataWidth)) u_datapath (
    .clk         (clk),
    .reset       (reset),
    .regSrc      (regSrc),
    .immSelect   (immSelect),
    .aluControl  (aluControl),
    .aluSrc      (aluSrc),
    .branchTaken (branchTaken),
    .memToReg    (memToReg),
    .regWrite    (regWrite),
    .stallF      (stallF),
    .stallD      (stallD),
    .flushD      (flushD),
    .forwardA    (forwardA),
    .forwardB    (forwardB),
    .instrD      (instrD),
    .flagsE      (flagsE),
    .match1EM    (match1EM),
    .match1EW    (match1EW),
    .match2EM    (match2EM),
    .match2EW    (match2EW),
    .match12DE   (match12DE),
    .pc          (pc),
    .instr       (instr),
    .dataAddr    (dataAddr),
    .writeData   (writeData),
    .readData    (readData)
  );

  controller u_controller (
    .clk         (clk),
    .reset       (reset),
    .instrD      (instrD),
    .flagsE      (flagsE),
    .stallD      (stallD),
    .flushD      (flushD),
    .flushE      (flushE),
    .regSrc      (regSrc),
    .immSelect   (immSelect),
    .aluControl  (aluControl),
    .aluSrc      (aluSrc),
    .branchTaken (branchTaken),
    .memWrite    (memWrite),
    .memToReg    (memToReg),
    .regWrite    (regWrite),
    .regWriteM   (regWriteM),
    .memToRegE   (memToRegE)
  );

  hazardUnit u_hazardUnit (
    .clk         (clk),
    .reset       (reset),
    .match1EM    (match1EM),
    .match1EW    (match1EW),
    .match2EM    (match2EM),
    .match2EW    (match2EW),
    .match12DE   (match12DE),
    .regWriteM   (regWriteM),
    .regWriteW   (regWrite),
    .memToRegE   (memToRegE),
    .branchTaken (branchTaken),
    .forwardA    (forwardA),
    .forwardB    (forwardB),
    .stallF      (stallF),
    .stallD      (stallD),
    .flushD      (flushD),
    .flushE      (flushE)
  );

endmodule

// ==== testbench/armCoreTb.sv ====
`timescale 1ns/1ps

module armCoreTb;

  localparam int DataWidth = 32;
  localparam int MemWords = 64;
  localparam logic [DataWidth-1:0] EndAddr = 'hFC;

  logic                 clk;
  logic                 reset;
  logic [DataWidth-1:0] pc;
  logic [31:0]          instr;
  logic                 memWrite;
  logic [DataWidth-1:0] dataAddr;
  logic [DataWidth-1:0] writeData;
  logic [DataWidth-1:0] readData;

  // Memory models and expected stores from the trace
  logic [31:0]          imem [0:MemWords-1];
  logic [DataWidth-1:0] dmem [0:MemWords-1];
  logic [DataWidth-1:0] expAddr [0:MemWords-1];
  logic [DataWidth-1:0] expData [0:MemWords-1];
  int                   expTest [0:MemWords-1];
  int                   numProg;
  int                   numStores;
  int                   storeIdx;
  int                   cycleCount;
  int                   cycleLimit;

  armCore #(.DataWidth(DataWidth)) u_dut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .instr     (instr),
    .memWrite  (memWrite),
    .dataAddr  (dataAddr),
    .writeData (writeData),
    .readData  (readData)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ========================================
  // Helpers
  // ========================================
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic loadTrace();
    int          fd;
    int          n;
    int          idx;
    int          testNum;
    string       line;
    logic [31:0] word;
    logic [31:0] addr;
    fd = $fopen("testbench/armTrace.txt", "r");
    if (fd == 0) begin
      abortRun("Cannot open the trace file testbench/armTrace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0) begin
          case (line[0])
            "P": begin
              n = $sscanf(line, "P %h", word);
              imem[numProg] = word;
              numProg++;
            end
            "D": begin
              n = $sscanf(line, "D %h %h", idx, word);
              dmem[idx] = word;
            end
            "S": begin
              n = $sscanf(line, "S %d %h %h", testNum, addr, word);
              expTest[numStores] = testNum;
              expAddr[numStores] = addr;
              expData[numStores] = word;
              numStores++;
            end
            // Comments and blank lines
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic checkStore(input string testName,
                            input logic [DataWidth-1:0] expA, input logic [DataWidth-1:0] expD,
                            input logic [DataWidth-1:0] actA, input logic [DataWidth-1:0] actD);
    if (actA !== expA) begin
      abortRun($sformatf("Fail %s: address expected %h actual %h", testName, expA, actA));
    end else if (actD !== expD) begin
      abortRun($sformatf("Fail %s: data expected %h actual %h", testName, expD, actD));
    end
  endtask

  task automatic recordStore();
    string name;
    if (storeIdx >= numStores) begin
      abortRun($sformatf("Store of %h to address %h after all expected stores",
                         writeData, dataAddr));
    end else begin
      name = $sformatf("behavior %0d store %0d", expTest[storeIdx], storeIdx);
      checkStore(name, expAddr[storeIdx], expData[storeIdx], dataAddr, writeData);
      dmem[dataAddr[7:2]] = writeData;
      storeIdx++;
      // Store to 0xFC closes the program
      if (dataAddr == EndAddr) begin
        if (storeIdx == numStores) begin
          $display("test passed");
          $finish;
        end else begin
          abortRun($sformatf("Program ended with %0d of %0d expected stores seen",
                             storeIdx, numStores));
        end
      end
    end
  endtask

  // ========================================
  // Stimulus and checking
  // ========================================
  initial begin
    reset = 1'b1;
    instr = '0;
    readData = '0;
    numProg = 0;
    numStores = 0;
    storeIdx = 0;
    cycleCount = 0;
    for (int i = 0; i < MemWords; i++) begin
      dmem[i] = DataWidth'(32'hC0DE0000 | i);
    end
    loadTrace();
    cycleLimit = 8 * numProg + 20;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

  // Memories answer mid-cycle, stores are checked while stable
  always @(negedge clk) begin
    instr = imem[pc[7:2]];
    readData = dmem[dataAddr[7:2]];
    if (!reset) begin
      cycleCount++;
      if (memWrite) begin
        recordStore();
      end else if (cycleCount > cycleLimit) begin
        abortRun($sformatf("Timeout after %0d cycles with no store to address 0xFC",
                           cycleLimit));
      end
    end
  end

endmodule

// ==== testbench/armTrace.txt ====
# P word: program word, placed in address order from 0
# D index word: initial data word at word index (hex); S test addr data: expected store
# ALU ops with register and immediate operands
P E2000000  # and r0, r0, #0
P E2801080  # add r1, r0, #0x80
P E280205A  # add r2, r0, #0x5a
P E280303C  # add r3, r0, #0x3c
P E0824003  # add r4, r2, r3
P E0435002  # sub r5, r3, r2
P E202600F  # and r6, r2, #0x0f
P E1827003  # orr r7, r2, r3
P E5814000  # str r4, [r1, #0]
P E5815004  # str r5, [r1, #4]
P E5816008  # str r6, [r1, #8]
P E581700C  # str r7, [r1, #12]
# Dependent chain
P E2828001  # add r8, r2, #1
P E0888008  # add r8, r8, r8
P E2488010  # sub r8, r8, #0x10
P E1888002  # orr r8, r8, r2
P E5818010  # str r8, [r1, #16]
# Load followed by use
P E5909040  # ldr r9, [r0, #0x40]
P E289A001  # add r10, r9, #1
P E581A014  # str r10, [r1, #20]
# Branches
P EA000001  # b skip two
P E5812030  # str r2, [r1, #0x30] never runs
P E5812034  # str r2, [r1, #0x34] never runs
P E252B05A  # subs r11, r2, #0x5a
P 0A000001  # beq skip two
P E5812038  # str r2, [r1, #0x38] never runs
P E581203C  # str r2, [r1, #0x3c] never runs
P 1A000001  # bne not taken
P E280C024  # add r12, r0, #0x24
P E581C018  # str r12, [r1, #24]
# Down offsets and failed conditions
P E5014008  # str r4, [r1, #-8]
P E511E008  # ldr r14, [r1, #-8]
P 128EE055  # addne r14, r14, #0x55 fails
P 15812040  # strne r2, [r1, #0x40] fails
P E581E01C  # str r14, [r1, #28]
# Final count store
P E280C009  # add r12, r0, #9
P E580C0FC  # str r12, [r0, #0xfc]
P EAFFFFFE  # b .
D 10 12345678
D 1E BADBAD00
S 1 00000080 00000096
S 1 00000084 FFFFFFE2
S 1 00000088 0000000A
S 1 0000008C 0000007E
S 2 00000090 000000FE
S 3 00000094 12345679
S 4 00000098 00000024
S 5 00000078 00000096
S 5 0000009C 00000096
S 6 000000FC 00000009

// ==== armCore.f ====
+incdir+include
logic/armPkg.sv
logic/regFile.sv
logic/alu.sv
logic/hazardUnit.sv
logic/controller.sv
logic/datapath.sv
logic/armCore.sv
testbench/armCoreTb.sv

// ==== Bender.yml ====
package:
  name: armCore

sources:
  - include_dirs:
      - include
    files:
      - logic/armPkg.sv
      - logic/regFile.sv
      - logic/alu.sv
      - logic/hazardUnit.sv
      - logic/controller.sv
      - logic/datapath.sv
      - logic/armCore.sv
  - target: test
    files:
      - testbench/armCoreTb.sv
